// ==== include/vldu_defs.svh ====
/*
 * Vector load unit sizes
 * Lane count, byte widths, queue depths and field widths
 */

`ifndef VLDU_DEFS_SVH
`define VLDU_DEFS_SVH

// Lanes and their word width
`define VLDU_NR_LANES 4
`define VLDU_LANE_BYTES 8
// One register-file word spans all lanes
`define VLDU_WORD_BYTES 32
// Read-channel beat width
`define VLDU_BEAT_BYTES 8

// Queue depths
`define VLDU_INSN_DEPTH 4
`define VLDU_RESULT_DEPTH 2

// Instruction fields
`define VLDU_ID_W 3
`define VLDU_WORDS_PER_VREG 8
`define VLDU_VL_W 9

`endif

// ==== logic/vldu_pkg.sv ====
/*
 * Vector load unit types
 * Instruction, element width and lane word types, plus the lane byte shuffle
 */

`include "vldu_defs.svh"

package vldu_pkg;

  // Element width of 2**vsew bytes
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

  typedef struct packed {
    logic [`VLDU_ID_W-1:0] id;
    logic [4:0]            vd;
    logic [`VLDU_VL_W-1:0] vl;
    vsew_e                 vsew;
  } insn_t;

  typedef logic [7:0]                     vaddr_t;
  typedef logic [`VLDU_LANE_BYTES*8-1:0]  lane_data_t;
  typedef logic [`VLDU_LANE_BYTES-1:0]    lane_be_t;
  // Byte position inside one register-file word
  typedef logic [$clog2(`VLDU_WORD_BYTES)-1:0] word_byte_t;

  // Map a sequential word byte to {lane, lane byte}
  // Element k lands in lane k mod lanes at slot k / lanes of that lane
  function automatic word_byte_t shuffle_byte(input word_byte_t seq, input vsew_e vsew);
    word_byte_t elem;
    word_byte_t ofs;
    word_byte_t slot;
    elem = seq >> vsew;
    ofs  = seq & ((word_byte_t'(1) << vsew) - word_byte_t'(1));
    slot = ((elem / `VLDU_NR_LANES) << vsew) + ofs;
    return word_byte_t'((elem % `VLDU_NR_LANES) * `VLDU_LANE_BYTES) + slot;
  endfunction

endpackage

// ==== logic/vldu_ifs.sv ====
/*
 * Vector load unit internal links
 * Issue handoff from the instruction queue and word pushes into the result queue
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

// Instruction at the issue pointer, handed to the packer
interface vldu_insn_if;
  import vldu_pkg::*;

  logic  valid;
  insn_t insn;
  // Packer consumed the last byte of this instruction
  logic  issue_done;

  modport queue  (output valid, output insn, input issue_done);
  modport packer (input valid, input insn, output issue_done);
endinterface

// Assembled register-file word, one push per valid and ready
interface vldu_word_if;
  import vldu_pkg::*;

  logic                                  valid;
  // Result queue not full
  logic                                  ready;
  logic [`VLDU_ID_W-1:0]                 id;
  vaddr_t                                addr;
  lane_data_t [`VLDU_NR_LANES-1:0]       wdata;
  lane_be_t   [`VLDU_NR_LANES-1:0]       be;

  modport source (output valid, output id, output addr, output wdata, output be,
                  input ready);
  modport sink   (input valid, input id, input addr, input wdata, input be,
                  output ready);
endinterface

// ==== logic/vldu_insn_queue.sv ====
/*
 * Vector load instruction queue
 * Holds in-flight loads with accept, issue and commit pointers,
 * counts committed bytes and reports each finished load
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

module vldu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vldu_pkg::insn_t       req_insn_i,
  // Issue side
  vldu_insn_if.queue            insn,
  // One result word retired
  input  logic                  word_pop_i,
  // Completion
  output logic                  done_valid_o,
  output logic [`VLDU_ID_W-1:0] done_id_o,
  output logic                  load_complete_o
);
  import vldu_pkg::*;

  localparam int unsigned DEPTH   = `VLDU_INSN_DEPTH;
  localparam int unsigned PNT_W   = $clog2(DEPTH);
  localparam int unsigned CNT_W   = PNT_W + 1;
  localparam int unsigned BYTES_W = `VLDU_VL_W + 3;

  ////////////////////////////////
  // Queue storage and pointers
  ////////////////////////////////

  insn_t              insn_q [DEPTH];
  logic [PNT_W-1:0]   accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue and held until commit
  logic [CNT_W-1:0]   issue_cnt_q, commit_cnt_q;
  logic [BYTES_W-1:0] commit_bytes_q, commit_bytes_d;
  logic               done_q;

  logic       accept;
  logic       commit_valid;
  logic       commit_last;
  logic [CNT_W-1:0] commit_left;
  insn_t      commit_insn;
  insn_t      next_commit;

  // Full when four loads are held whether issued or not
  assign req_ready_o  = (commit_cnt_q != CNT_W'(DEPTH));
  assign accept       = req_valid_i && req_ready_o;

  assign insn.valid   = (issue_cnt_q != '0);
  assign insn.insn    = insn_q[issue_pnt_q];

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_insn  = insn_q[commit_pnt_q];
  assign next_commit  = insn_q[commit_pnt_q + PNT_W'(1)];
  // Last word of the committing load retires
  assign commit_last  = commit_valid && word_pop_i &&
                        (commit_bytes_q <= BYTES_W'(`VLDU_WORD_BYTES));
  assign commit_left  = commit_cnt_q - CNT_W'(commit_last);

  ////////////////////////////////
  // Commit byte counter
  ////////////////////////////////

  always_comb begin
    commit_bytes_d = commit_bytes_q;
    // Saturating count down by one word per retire
    if (commit_valid && word_pop_i) begin
      commit_bytes_d = commit_last ? '0 : commit_bytes_q - BYTES_W'(`VLDU_WORD_BYTES);
    end
    // Next held load takes over the counter
    if (commit_last && commit_left != '0) begin
      commit_bytes_d = BYTES_W'(next_commit.vl) << next_commit.vsew;
    end
    // New request is the next to commit once the queue drains
    if (accept && commit_left == '0) begin
      commit_bytes_d = BYTES_W'(req_insn_i.vl) << req_insn_i.vsew;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      commit_bytes_q <= '0;
      done_q         <= 1'b0;
    end else begin
      if (accept) accept_pnt_q <= accept_pnt_q + PNT_W'(1);
      if (insn.issue_done) issue_pnt_q <= issue_pnt_q + PNT_W'(1);
      if (commit_last) commit_pnt_q <= commit_pnt_q + PNT_W'(1);
      issue_cnt_q    <= issue_cnt_q + CNT_W'(accept) - CNT_W'(insn.issue_done);
      commit_cnt_q   <= commit_left + CNT_W'(accept);
      commit_bytes_q <= commit_bytes_d;
      // Completion pulse one cycle after the final retire
      done_q         <= commit_last;
    end
  end

  // Instruction slots and the reported id
  always_ff @(posedge clk_i) begin
    if (accept) insn_q[accept_pnt_q] <= req_insn_i;
    if (commit_last) done_id_o <= commit_insn.id;
  end

  assign done_valid_o    = done_q;
  assign load_complete_o = done_q;

endmodule

// ==== logic/vldu_beat_packer.sv ====
/*
 * Vector load beat packer
 * Unpacks read beats into lane-shuffled register-file words
 * for the instruction at the issue pointer
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

module vldu_beat_packer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  vldu_insn_if.packer                    insn,
  // Read channel
  input  logic                           r_valid_i,
  input  logic [`VLDU_BEAT_BYTES*8-1:0]  r_data_i,
  output logic                           r_ready_o,
  // Words towards the result queue
  vldu_word_if.source                    word
);
  import vldu_pkg::*;

  localparam int unsigned BYTES_W    = `VLDU_VL_W + 3;
  localparam int unsigned BEAT_IDX_W = $clog2(`VLDU_WORD_BYTES / `VLDU_BEAT_BYTES);
  localparam int unsigned WORD_IDX_W = $clog2(`VLDU_WORDS_PER_VREG);
  localparam int unsigned LB_W       = $clog2(`VLDU_LANE_BYTES);
  localparam int unsigned SEQ_W      = $clog2(`VLDU_WORD_BYTES);

  // Remaining bytes are valid once the first beat is taken
  logic                  started_q;
  logic [BYTES_W-1:0]    rem_q, rem_cur, total_bytes;
  logic [BEAT_IDX_W-1:0] beat_idx_q;
  logic [WORD_IDX_W-1:0] word_idx_q;

  // Word under assembly
  lane_data_t [`VLDU_NR_LANES-1:0] wdata_q, wdata_d;
  lane_be_t   [`VLDU_NR_LANES-1:0] be_q, be_d;

  word_byte_t             seq;
  word_byte_t             sh;
  logic [SEQ_W-LB_W-1:0]  lane_sel;
  logic [LB_W-1:0]        byte_sel;

  logic consume, last_beat, push;

  assign total_bytes = BYTES_W'(insn.insn.vl) << insn.insn.vsew;
  assign rem_cur     = started_q ? rem_q : total_bytes;
  assign last_beat   = (rem_cur <= BYTES_W'(`VLDU_BEAT_BYTES));

  // One beat per cycle while an instruction waits and a result slot is free
  assign consume   = insn.valid && r_valid_i && word.ready;
  assign r_ready_o = consume;
  // Push on the fourth beat of a word or the load's last beat
  assign push      = consume && (last_beat || (beat_idx_q == '1));

  //////////////////////////////
  // Byte placement
  //////////////////////////////

  always_comb begin
    // First beat of a word starts clean
    wdata_d  = (beat_idx_q == '0) ? '0 : wdata_q;
    be_d     = (beat_idx_q == '0) ? '0 : be_q;
    seq      = '0;
    sh       = '0;
    lane_sel = '0;
    byte_sel = '0;
    for (int i = 0; i < `VLDU_BEAT_BYTES; i++) begin
      seq      = word_byte_t'(int'(beat_idx_q) * `VLDU_BEAT_BYTES + i);
      sh       = shuffle_byte(seq, insn.insn.vsew);
      lane_sel = sh[SEQ_W-1:LB_W];
      byte_sel = sh[LB_W-1:0];
      // Bytes past the instruction tail are dropped
      if (BYTES_W'(i) < rem_cur) begin
        wdata_d[lane_sel][8*byte_sel +: 8] = r_data_i[8*i +: 8];
        be_d[lane_sel][byte_sel]           = 1'b1;
      end
    end
  end

  assign word.valid = push;
  assign word.id    = insn.insn.id;
  // Word j of the register sits at vd * words per register + j
  assign word.addr  = vaddr_t'(insn.insn.vd) * vaddr_t'(`VLDU_WORDS_PER_VREG) +
                      vaddr_t'(word_idx_q);
  assign word.wdata = wdata_d;
  assign word.be    = be_d;

  assign insn.issue_done = consume && last_beat;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q  <= 1'b0;
      rem_q      <= '0;
      beat_idx_q <= '0;
      word_idx_q <= '0;
    end else if (consume) begin
      started_q  <= !last_beat;
      rem_q      <= last_beat ? '0 : rem_cur - BYTES_W'(`VLDU_BEAT_BYTES);
      beat_idx_q <= push ? '0 : beat_idx_q + BEAT_IDX_W'(1);
      if (last_beat) begin
        word_idx_q <= '0;
      end else if (push) begin
        word_idx_q <= word_idx_q + WORD_IDX_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      wdata_q <= wdata_d;
      be_q    <= be_d;
    end
  end

endmodule

// ==== logic/vldu_result_queue.sv ====
/*
 * Vector load result queue
 * Two word slots offered to all lanes, each lane released by its own grant
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

module vldu_result_queue (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  vldu_word_if.sink                                      word,
  // Lane write ports
  output logic                 [`VLDU_NR_LANES-1:0]      lane_req_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_ID_W-1:0]      lane_id_o,
  output vldu_pkg::vaddr_t     [`VLDU_NR_LANES-1:0]      lane_addr_o,
  output vldu_pkg::lane_data_t [`VLDU_NR_LANES-1:0]      lane_wdata_o,
  output vldu_pkg::lane_be_t   [`VLDU_NR_LANES-1:0]      lane_be_o,
  input  logic                 [`VLDU_NR_LANES-1:0]      lane_gnt_i,
  // Entry retired
  output logic                                           word_pop_o
);
  import vldu_pkg::*;

  localparam int unsigned DEPTH = `VLDU_RESULT_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned NR    = `VLDU_NR_LANES;

  // Payload slots
  logic [`VLDU_ID_W-1:0] id_q    [DEPTH];
  vaddr_t                addr_q  [DEPTH];
  lane_data_t [NR-1:0]   wdata_q [DEPTH];
  lane_be_t   [NR-1:0]   be_q    [DEPTH];
  // Lanes still owed this entry
  logic [NR-1:0]         pend_q  [DEPTH];

  logic [PNT_W-1:0] rd_pnt_q, wr_pnt_q;
  logic [PNT_W:0]   cnt_q;
  logic [NR-1:0]    pend_next;
  logic             push, pop;

  assign word.ready = (cnt_q != (PNT_W+1)'(DEPTH));
  assign push       = word.valid && word.ready;

  // Read entry goes out to every lane
  assign lane_req_o   = pend_q[rd_pnt_q];
  assign lane_id_o    = {NR{id_q[rd_pnt_q]}};
  assign lane_addr_o  = {NR{addr_q[rd_pnt_q]}};
  assign lane_wdata_o = wdata_q[rd_pnt_q];
  assign lane_be_o    = be_q[rd_pnt_q];

  // Retire as soon as the last owed lane grants
  assign pend_next  = lane_req_o & ~lane_gnt_i;
  assign pop        = (|lane_req_o) && (pend_next == '0);
  assign word_pop_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int e = 0; e < DEPTH; e++) begin
        pend_q[e] <= '0;
      end
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      pend_q[rd_pnt_q] <= pend_next;
      // A fresh entry owes every lane
      if (push) begin
        pend_q[wr_pnt_q] <= '1;
        wr_pnt_q         <= wr_pnt_q + PNT_W'(1);
      end
      if (pop) rd_pnt_q <= rd_pnt_q + PNT_W'(1);
      cnt_q <= cnt_q + (PNT_W+1)'(push) - (PNT_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_pnt_q]    <= word.id;
      addr_q[wr_pnt_q]  <= word.addr;
      wdata_q[wr_pnt_q] <= word.wdata;
      be_q[wr_pnt_q]    <= word.be;
    end
  end

endmodule

// ==== logic/vldu_top.sv ====
/*
 * Vector load unit
 * Instruction queue, beat packer and result queue behind plain ports
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

module vldu_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer request
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  logic [`VLDU_ID_W-1:0]                       req_id_i,
  input  logic [4:0]                                  req_vd_i,
  input  logic [`VLDU_VL_W-1:0]                       req_vl_i,
  input  vldu_pkg::vsew_e                             req_vsew_i,
  // Read channel
  input  logic                                        r_valid_i,
  input  logic [`VLDU_BEAT_BYTES*8-1:0]               r_data_i,
  output logic                                        r_ready_o,
  // Lanes
  output logic                 [`VLDU_NR_LANES-1:0]   lane_req_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_ID_W-1:0]   lane_id_o,
  output vldu_pkg::vaddr_t     [`VLDU_NR_LANES-1:0]   lane_addr_o,
  output vldu_pkg::lane_data_t [`VLDU_NR_LANES-1:0]   lane_wdata_o,
  output vldu_pkg::lane_be_t   [`VLDU_NR_LANES-1:0]   lane_be_o,
  input  logic                 [`VLDU_NR_LANES-1:0]   lane_gnt_i,
  // Completion
  output logic                                        done_valid_o,
  output logic [`VLDU_ID_W-1:0]                       done_id_o,
  output logic                                        load_complete_o
);
  import vldu_pkg::*;

  insn_t req_insn;
  logic  word_pop;

  vldu_insn_if insn_if ();
  vldu_word_if word_if ();

  // Request fields into one instruction record
  assign req_insn = '{id: req_id_i, vd: req_vd_i, vl: req_vl_i, vsew: req_vsew_i};

  ////////////////////////////////
  // Accept, issue and commit
  ////////////////////////////////

  vldu_insn_queue vldu_insn_queue_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_insn_i      (req_insn),
    .insn            (insn_if.queue),
    .word_pop_i      (word_pop),
    .done_valid_o    (done_valid_o),
    .done_id_o       (done_id_o),
    .load_complete_o (load_complete_o)
  );

  vldu_beat_packer vldu_beat_packer_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .insn      (insn_if.packer),
    .r_valid_i (r_valid_i),
    .r_data_i  (r_data_i),
    .r_ready_o (r_ready_o),
    .word      (word_if.source)
  );

  vldu_result_queue vldu_result_queue_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word         (word_if.sink),
    .lane_req_o   (lane_req_o),
    .lane_id_o    (lane_id_o),
    .lane_addr_o  (lane_addr_o),
    .lane_wdata_o (lane_wdata_o),
    .lane_be_o    (lane_be_o),
    .lane_gnt_i   (lane_gnt_i),
    .word_pop_o   (word_pop)
  );

endmodule

// ==== verif/vldu_tb.sv ====
/*
 * Vector load unit testbench
 * Random beats and grants checked against a byte-level load model
 */

`timescale 1ns/1ns

`include "vldu_defs.svh"

module vldu_tb;
  import vldu_pkg::*;

  localparam int unsigned NR  = `VLDU_NR_LANES;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          req_valid_i;
  logic                          req_ready_o;
  logic [`VLDU_ID_W-1:0]         req_id_i;
  logic [4:0]                    req_vd_i;
  logic [`VLDU_VL_W-1:0]         req_vl_i;
  vsew_e                         req_vsew_i;
  logic                          r_valid_i = 1'b0;
  logic [63:0]                   r_data_i = '0;
  logic                          r_ready_o;
  logic [NR-1:0]                 lane_req_o;
  logic [NR-1:0][`VLDU_ID_W-1:0] lane_id_o;
  vaddr_t     [NR-1:0]           lane_addr_o;
  lane_data_t [NR-1:0]           lane_wdata_o;
  lane_be_t   [NR-1:0]           lane_be_o;
  logic [NR-1:0]                 lane_gnt_i = '0;
  logic                          done_valid_o;
  logic [`VLDU_ID_W-1:0]         done_id_o;
  logic                          load_complete_o;

  // Beats still to send and words still owed to each lane
  logic [31:0]           lfsr = 32'hae16;
  logic [63:0]           beat_q [$];
  logic [255:0]          exp_wdata_q [$];
  logic [31:0]           exp_be_q [$];
  vaddr_t                exp_addr_q [$];
  logic [`VLDU_ID_W-1:0] exp_id_q [$];
  logic [`VLDU_ID_W-1:0] exp_done_q [$];
  // Word count at the end of each load
  int                    exp_end_q [$];
  int lane_idx [NR] = '{default: 0};
  int done_idx = 0;
  int retired = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int test_no = 0;
  int test_base = 0;
  int done_base;
  logic done_due = 1'b0;
  logic hold_read = 1'b0;
  logic grant_rand = 1'b0;

  vldu_top vldu_top_i (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Lane * 8 + lane byte of byte s in a word of 2**sew byte elements
  function automatic int lane_byte_pos(input int s, input int sew);
    int w;
    int k;
    w = 1 << sew;
    k = s / w;
    return (k % NR) * `VLDU_LANE_BYTES + (k / NR) * w + s % w;
  endfunction

  function automatic bit all_drained();
    if (done_idx != exp_done_q.size()) return 1'b0;
    for (int l = 0; l < NR; l++) begin
      if (lane_idx[l] != exp_addr_q.size()) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // Draw the beats of an accepted load and build its shuffled words
  task automatic model_load(input logic [`VLDU_ID_W-1:0] id, input logic [4:0] vd,
                            input int vl, input int sew);
    int bytes;
    int g;
    int pos;
    logic [63:0]  beats [$];
    logic [63:0]  beat;
    logic [255:0] wdata;
    logic [31:0]  be;
    bytes = vl << sew;
    for (int b = 0; b < (bytes + 7) / 8; b++) begin
      beats.push_back(rand_bits(64));
      beat_q.push_back(beats[b]);
    end
    for (int j = 0; j < (bytes + 31) / 32; j++) begin
      wdata = '0;
      be    = '0;
      for (int s = 0; s < `VLDU_WORD_BYTES; s++) begin
        g = j * `VLDU_WORD_BYTES + s;
        // Tail bytes stay disabled
        if (g < bytes) begin
          pos  = lane_byte_pos(s, sew);
          beat = beats[g / 8];
          wdata[8*pos +: 8] = beat[8*(g%8) +: 8];
          be[pos] = 1'b1;
        end
      end
      exp_wdata_q.push_back(wdata);
      exp_be_q.push_back(be);
      exp_addr_q.push_back(vaddr_t'(int'(vd) * `VLDU_WORDS_PER_VREG + j));
      exp_id_q.push_back(id);
    end
    exp_end_q.push_back(exp_addr_q.size());
    exp_done_q.push_back(id);
  endtask

  // Entered and left 10 ns after a rising edge
  task automatic issue_load(input logic [`VLDU_ID_W-1:0] id, input logic [4:0] vd,
                            input int vl, input vsew_e sew);
    req_id_i    = id;
    req_vd_i    = vd;
    req_vl_i    = `VLDU_VL_W'(vl);
    req_vsew_i  = sew;
    req_valid_i = 1'b1;
    do @(posedge clk_i); while (!req_ready_o);
    #10;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (!all_drained()) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic end_test(input string name);
    test_no++;
    $display("test %0d %s: %s, %0d errors", test_no, name,
             (errors == test_base) ? "ok" : "failed", errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////
  // Monitor and checks
  //////////////////////////////

  always @(posedge clk_i) begin : monitor
    logic [255:0] w_exp;
    logic [31:0]  be_exp;
    int           min_idx;
    if (rst_ni) begin
      // Completion pulses one cycle after the last lane takes a load's final word
      check_value("done_valid_o", 256'(done_valid_o), 256'(done_due));
      check_value("load_complete_o", 256'(load_complete_o), 256'(done_due));
      if (done_due) begin
        check_value("done_id_o", 256'(done_id_o), 256'(exp_done_q[done_idx]));
        done_idx++;
      end
      if (r_valid_i && r_ready_o) void'(beat_q.pop_front());
      if (req_valid_i && req_ready_o) begin
        model_load(req_id_i, req_vd_i, int'(req_vl_i), int'(req_vsew_i));
      end
      for (int l = 0; l < NR; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          if (lane_idx[l] >= exp_addr_q.size()) begin
            $display("lane %0d wrote a word that the model does not expect", l);
            errors++;
          end else begin
            w_exp  = exp_wdata_q[lane_idx[l]];
            be_exp = exp_be_q[lane_idx[l]];
            check_value($sformatf("lane_wdata_o[%0d]", l), 256'(lane_wdata_o[l]),
                        256'(w_exp[64*l +: 64]));
            check_value($sformatf("lane_be_o[%0d]", l), 256'(lane_be_o[l]),
                        256'(be_exp[8*l +: 8]));
            check_value($sformatf("lane_addr_o[%0d]", l), 256'(lane_addr_o[l]),
                        256'(exp_addr_q[lane_idx[l]]));
            check_value($sformatf("lane_id_o[%0d]", l), 256'(lane_id_o[l]),
                        256'(exp_id_q[lane_idx[l]]));
            lane_idx[l]++;
          end
        end
      end
      // A word retires once every lane has taken it
      min_idx = lane_idx[0];
      for (int l = 1; l < NR; l++) begin
        if (lane_idx[l] < min_idx) min_idx = lane_idx[l];
      end
      done_due = (retired < exp_end_q.size()) && (min_idx >= exp_end_q[retired]);
      if (done_due) retired++;
    end
  end

  // A lane's request and payload hold until its grant
  for (genvar l = 0; l < NR; l++) begin : g_lane_hold
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lane_req_o[l] && !lane_gnt_i[l] |=> lane_req_o[l] && $stable(lane_wdata_o[l]) &&
        $stable(lane_be_o[l]) && $stable(lane_addr_o[l]))
      else begin
        $display("lane %0d dropped or changed its request before the grant", l);
        errors++;
      end
  end

  //////////////////////////////
  // Read beats and lane grants
  //////////////////////////////

  always @(posedge clk_i) begin : drive_inputs
    logic        hold_now;
    logic        rand_now;
    logic [63:0] gnt_bits;
    hold_now = hold_read;
    rand_now = grant_rand;
    #10;
    r_valid_i = !hold_now && (beat_q.size() != 0);
    r_data_i  = (beat_q.size() != 0) ? beat_q[0] : '0;
    if (rand_now) begin
      gnt_bits   = rand_bits(NR);
      lane_gnt_i = gnt_bits[NR-1:0];
    end else begin
      lane_gnt_i = '1;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with loads still outstanding", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_id_i    = '0;
    req_vd_i    = '0;
    req_vl_i    = '0;
    req_vsew_i  = EW8;
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    check_value("req_ready_o", 256'(req_ready_o), 256'(1));
    check_value("lane_req_o", 256'(lane_req_o), 256'(0));
    check_value("r_ready_o", 256'(r_ready_o), 256'(0));
    check_value("done_valid_o", 256'(done_valid_o), 256'(0));
    end_test("reset state");

    // Four full beats into one word at address 24
    issue_load(3'd1, 5'd3, 4, EW64);
    wait_idle();
    end_test("EW64 word placement");

    // 40 bytes where the second word holds only 8
    issue_load(3'd2, 5'd5, 40, EW8);
    wait_idle();
    end_test("EW8 partial last word");

    grant_rand = 1'b1;
    issue_load(3'd3, 5'd7, 32, EW16);
    issue_load(3'd4, 5'd2, 20, EW32);
    wait_idle();
    end_test("random grants");

    issue_load(3'd5, 5'd1, 12, EW16);
    issue_load(3'd6, 5'd9, 9, EW64);
    issue_load(3'd7, 5'd4, 3, EW32);
    issue_load(3'd0, 5'd12, 33, EW8);
    wait_idle();
    end_test("completion order");

    // No beats until the queue has filled
    grant_rand = 1'b0;
    hold_read  = 1'b1;
    issue_load(3'd1, 5'd0, 8, EW32);
    issue_load(3'd2, 5'd1, 4, EW64);
    issue_load(3'd3, 5'd2, 16, EW8);
    issue_load(3'd4, 5'd3, 8, EW16);
    repeat (3) begin
      check_value("req_ready_o", 256'(req_ready_o), 256'(0));
      @(posedge clk_i);
      #10;
    end
    hold_read = 1'b0;
    done_base = retired;
    // Room opens only as the first held load completes
    do begin
      @(posedge clk_i);
      #10;
      assert (!req_ready_o || retired > done_base) else begin
        $display("req_ready_o rose before the first held load completed");
        errors++;
      end
    end while (retired == done_base);
    check_value("req_ready_o", 256'(req_ready_o), 256'(1));
    wait_idle();
    end_test("queue full");

    $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
logic/vldu_pkg.sv
logic/vldu_ifs.sv
logic/vldu_insn_queue.sv
logic/vldu_beat_packer.sv
logic/vldu_result_queue.sv
logic/vldu_top.sv
verif/vldu_tb.sv
